//--- rtl/flight_cfg.svh
// Flight path constants
`ifndef FLIGHT_CFG_SVH
`define FLIGHT_CFG_SVH

// sys_clk cycles per microsecond
`define SYS_CLK_PER_US 10

// Valid stick pulse range in us
`define REC_MIN_US 1000
`define REC_MAX_US 2000

// Microseconds above minimum to stick value
`define REC_SHIFT 2

// Stick value at neutral
`define REC_CENTER 125

// Mixer limits
`define MOTOR_MAX 250
`define THROTTLE_IDLE 10
`define AXIS_SHIFT 1

// ESC frame and pulse shape in us
`define ESC_PERIOD_US 2500
`define ESC_MIN_US 1000
`define ESC_US_PER_STEP 4

`endif

//--- rtl/flight_pkg.sv
// Flight path shared types
package flight_pkg;

    // Stick value, 0 to 250
    typedef logic [7:0] rec_val_t;

    // Signed axis rate command
    typedef logic signed [9:0] axis_rate_t;

    // Measured attitude angle in degrees
    typedef logic signed [7:0] angle_t;

    // Motor rate, 0 to 250
    typedef logic [7:0] motor_rate_t;

    // Receiver channel phase
    typedef enum logic {
        rx_wait_rise,
        rx_high
    } rx_state_e;

    // ESC output phase within a frame
    typedef enum logic {
        esc_high,
        esc_low
    } esc_state_e;

endpackage

//--- rtl/us_tick.sv
// Microsecond tick divider
`timescale 1ns/1ps
`include "flight_cfg.svh"

module us_tick (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_pulse
);

    // Enough bits to hold one microsecond of cycles
    localparam int CNT_W = $clog2(`SYS_CLK_PER_US);

    logic [CNT_W-1:0] cyc_cnt;

    // Pulse on the wrap, so the first one lands a full us after reset
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            cyc_cnt  <= '0;
            us_pulse <= 1'b0;
        end else begin
            if (cyc_cnt == CNT_W'(`SYS_CLK_PER_US - 1)) begin
                cyc_cnt  <= '0;
                us_pulse <= 1'b1;
            end else begin
                cyc_cnt  <= cyc_cnt + 1'b1;
                us_pulse <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/rc_receiver.sv
// RC servo pulse receiver
`timescale 1ns/1ps
`include "flight_cfg.svh"

module rc_receiver import flight_pkg::*; (
    input  logic     sys_clk,
    input  logic     resetn,
    input  logic     us_pulse,
    input  logic     throttle_pwm,
    input  logic     roll_pwm,
    input  logic     pitch_pwm,
    input  logic     yaw_pwm,
    output rec_val_t throttle_val,
    output rec_val_t roll_val,
    output rec_val_t pitch_val,
    output rec_val_t yaw_val
);

    // Channel order: throttle, roll, pitch, yaw
    logic [3:0]  pwm_in;
    logic [3:0]  sync_1;
    logic [3:0]  sync_2;
    rx_state_e   rx_state [4];
    logic [11:0] width_us [4];
    rec_val_t    val      [4];

    assign pwm_in = {yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};

    // Clamp to the stick range, then scale to 0..250
    function automatic rec_val_t scale_width(input logic [11:0] w);
        logic [11:0] above_min;
        above_min = w - 12'(`REC_MIN_US);
        if (w <= 12'(`REC_MIN_US)) begin
            return '0;
        end else if (w >= 12'(`REC_MAX_US)) begin
            return rec_val_t'((`REC_MAX_US - `REC_MIN_US) >> `REC_SHIFT);
        end else begin
            return rec_val_t'(above_min >> `REC_SHIFT);
        end
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            sync_1 <= '0;
            sync_2 <= '0;
            for (int i = 0; i < 4; i++) begin
                rx_state[i] <= rx_wait_rise;
                width_us[i] <= '0;
                val[i]      <= '0;
            end
        end else begin
            // Two-flop synchronizer on the raw pins
            sync_1 <= pwm_in;
            sync_2 <= sync_1;
            for (int i = 0; i < 4; i++) begin
                case (rx_state[i])
                    rx_wait_rise: begin
                        // First high cycle counts too
                        if (sync_2[i]) begin
                            rx_state[i] <= rx_high;
                            width_us[i] <= us_pulse ? 12'd1 : 12'd0;
                        end
                    end
                    rx_high: begin
                        if (sync_2[i]) begin
                            // Saturate just past the top of the range
                            if (us_pulse && (width_us[i] <= 12'(`REC_MAX_US))) begin
                                width_us[i] <= width_us[i] + 1'b1;
                            end
                        end else begin
                            // Falling edge, publish the new value
                            val[i]      <= scale_width(width_us[i]);
                            rx_state[i] <= rx_wait_rise;
                        end
                    end
                    default: rx_state[i] <= rx_wait_rise;
                endcase
            end
        end
    end

    // Values hold until the channel's next complete pulse
    assign throttle_val = val[0];
    assign roll_val     = val[1];
    assign pitch_val    = val[2];
    assign yaw_val      = val[3];

endmodule

//--- rtl/angle_controller.sv
// Angle controller
`timescale 1ns/1ps
`include "flight_cfg.svh"

module angle_controller import flight_pkg::*; (
    input  logic       sys_clk,
    input  logic       resetn,
    input  logic       imu_valid,
    input  rec_val_t   throttle_val,
    input  rec_val_t   roll_val,
    input  rec_val_t   pitch_val,
    input  rec_val_t   yaw_val,
    input  angle_t     roll_actual,
    input  angle_t     pitch_actual,
    output rec_val_t   thr_cmd,
    output axis_rate_t roll_rate,
    output axis_rate_t pitch_rate,
    output axis_rate_t yaw_rate,
    output logic       ctrl_done
);

    // Sticks re-centred around neutral
    axis_rate_t roll_target;
    axis_rate_t pitch_target;
    axis_rate_t yaw_target;

    // Measured angles sign extended to rate width
    axis_rate_t roll_meas;
    axis_rate_t pitch_meas;

    // Angle error per axis
    axis_rate_t roll_err;
    axis_rate_t pitch_err;

    // Zero extend stick, then take off the centre
    assign roll_target  = axis_rate_t'({2'b00, roll_val}) - axis_rate_t'(`REC_CENTER);
    assign pitch_target = axis_rate_t'({2'b00, pitch_val}) - axis_rate_t'(`REC_CENTER);
    assign yaw_target   = axis_rate_t'({2'b00, yaw_val}) - axis_rate_t'(`REC_CENTER);

    assign roll_meas  = axis_rate_t'(roll_actual);
    assign pitch_meas = axis_rate_t'(pitch_actual);

    // Worst case is about +-253, well inside 10 bits
    assign roll_err  = roll_target - roll_meas;
    assign pitch_err = pitch_target - pitch_meas;

    // No angle loop on yaw, stick only
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            thr_cmd    <= '0;
            roll_rate  <= '0;
            pitch_rate <= '0;
            yaw_rate   <= '0;
            ctrl_done  <= 1'b0;
        end else begin
            // Done strobe trails the start by one cycle
            ctrl_done <= imu_valid;
            if (imu_valid) begin
                thr_cmd    <= throttle_val;
                roll_rate  <= roll_err;
                pitch_rate <= pitch_err;
                yaw_rate   <= yaw_target;
            end
        end
    end

endmodule

//--- rtl/motor_mixer.sv
// X-quad motor mixer
`timescale 1ns/1ps
`include "flight_cfg.svh"

module motor_mixer import flight_pkg::*; (
    input  logic        sys_clk,
    input  logic        resetn,
    input  logic        ctrl_done,
    input  rec_val_t    thr_cmd,
    input  axis_rate_t  roll_rate,
    input  axis_rate_t  pitch_rate,
    input  axis_rate_t  yaw_rate,
    output motor_rate_t motor_1_rate,
    output motor_rate_t motor_2_rate,
    output motor_rate_t motor_3_rate,
    output motor_rate_t motor_4_rate
);

    // 12 bits signed covers 250 + 3 * 256 and below zero
    logic signed [11:0] thr;
    logic signed [11:0] r;
    logic signed [11:0] p;
    logic signed [11:0] y;
    logic signed [11:0] sum_1;
    logic signed [11:0] sum_2;
    logic signed [11:0] sum_3;
    logic signed [11:0] sum_4;
    logic               idle;

    // Saturate a mixed sum into the motor range
    function automatic motor_rate_t clamp_rate(input logic signed [11:0] s);
        if (s < 0) begin
            return '0;
        end else if (s > `MOTOR_MAX) begin
            return motor_rate_t'(`MOTOR_MAX);
        end else begin
            return s[7:0];
        end
    endfunction

    // Sign extended arithmetic shift rounds toward minus infinity
    assign thr = {4'b0000, thr_cmd};
    assign r   = 12'(roll_rate) >>> `AXIS_SHIFT;
    assign p   = 12'(pitch_rate) >>> `AXIS_SHIFT;
    assign y   = 12'(yaw_rate) >>> `AXIS_SHIFT;

    // Motor layout per X frame
    assign sum_1 = thr + p + r - y;
    assign sum_2 = thr + p - r + y;
    assign sum_3 = thr - p - r - y;
    assign sum_4 = thr - p + r + y;

    // Low throttle shuts everything down
    assign idle = thr_cmd < `THROTTLE_IDLE;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else if (ctrl_done) begin
            motor_1_rate <= idle ? '0 : clamp_rate(sum_1);
            motor_2_rate <= idle ? '0 : clamp_rate(sum_2);
            motor_3_rate <= idle ? '0 : clamp_rate(sum_3);
            motor_4_rate <= idle ? '0 : clamp_rate(sum_4);
        end
    end

endmodule

//--- rtl/esc_pwm.sv
// ESC pulse generators
`timescale 1ns/1ps
`include "flight_cfg.svh"

module esc_pwm import flight_pkg::*; (
    input  logic        sys_clk,
    input  logic        resetn,
    input  logic        us_pulse,
    input  motor_rate_t motor_1_rate,
    input  motor_rate_t motor_2_rate,
    input  motor_rate_t motor_3_rate,
    input  motor_rate_t motor_4_rate,
    output logic        motor_1_pwm,
    output logic        motor_2_pwm,
    output logic        motor_3_pwm,
    output logic        motor_4_pwm
);

    logic [11:0] frame_us;
    logic        frame_start;
    motor_rate_t rate_in   [4];
    motor_rate_t shadow    [4];
    logic [11:0] pulse_us  [4];
    esc_state_e  esc_state [4];

    assign rate_in[0] = motor_1_rate;
    assign rate_in[1] = motor_2_rate;
    assign rate_in[2] = motor_3_rate;
    assign rate_in[3] = motor_4_rate;

    // Count zero marks the frame boundary
    assign frame_start = us_pulse && (frame_us == '0);

    // Pulse width from the latched rate, 1000 to 2000 us
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            pulse_us[i] = 12'(`ESC_MIN_US) + 12'(`ESC_US_PER_STEP) * {4'b0000, shadow[i]};
        end
    end

    // Rates only change at frame start
    always_ff @(posedge sys_clk) begin
        if (frame_start) begin
            for (int i = 0; i < 4; i++) begin
                shadow[i] <= rate_in[i];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            frame_us <= '0;
            for (int i = 0; i < 4; i++) begin
                esc_state[i] <= esc_low;
            end
        end else if (us_pulse) begin
            frame_us <= (frame_us == 12'(`ESC_PERIOD_US - 1)) ? '0 : frame_us + 1'b1;
            for (int i = 0; i < 4; i++) begin
                if (frame_start) begin
                    esc_state[i] <= esc_high;
                end else if (esc_state[i] == esc_high && frame_us == pulse_us[i]) begin
                    esc_state[i] <= esc_low;
                end
            end
        end
    end

    assign motor_1_pwm = (esc_state[0] == esc_high);
    assign motor_2_pwm = (esc_state[1] == esc_high);
    assign motor_3_pwm = (esc_state[2] == esc_high);
    assign motor_4_pwm = (esc_state[3] == esc_high);

endmodule

//--- rtl/flight_core.sv
// Stick to motor flight core
`timescale 1ns/1ps

module flight_core import flight_pkg::*; (
    input  logic   sys_clk,
    input  logic   resetn,
    input  logic   throttle_pwm,
    input  logic   roll_pwm,
    input  logic   pitch_pwm,
    input  logic   yaw_pwm,
    input  logic   imu_valid,
    input  angle_t roll_actual,
    input  angle_t pitch_actual,
    output logic   motor_1_pwm,
    output logic   motor_2_pwm,
    output logic   motor_3_pwm,
    output logic   motor_4_pwm
);

    // Microsecond pacing
    logic us_pulse;

    // Receiver levels
    rec_val_t throttle_val;
    rec_val_t roll_val;
    rec_val_t pitch_val;
    rec_val_t yaw_val;

    // Controller results
    rec_val_t   thr_cmd;
    axis_rate_t roll_rate;
    axis_rate_t pitch_rate;
    axis_rate_t yaw_rate;
    logic       ctrl_done;

    // Mixer results
    motor_rate_t motor_1_rate;
    motor_rate_t motor_2_rate;
    motor_rate_t motor_3_rate;
    motor_rate_t motor_4_rate;

    us_tick tick0 (.sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse));

    rc_receiver rx0 (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .throttle_pwm(throttle_pwm), .roll_pwm(roll_pwm),
        .pitch_pwm(pitch_pwm), .yaw_pwm(yaw_pwm),
        .throttle_val(throttle_val), .roll_val(roll_val),
        .pitch_val(pitch_val), .yaw_val(yaw_val)
    );

    // Started directly by the attitude strobe
    angle_controller ac0 (
        .sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid),
        .throttle_val(throttle_val), .roll_val(roll_val),
        .pitch_val(pitch_val), .yaw_val(yaw_val),
        .roll_actual(roll_actual), .pitch_actual(pitch_actual),
        .thr_cmd(thr_cmd), .roll_rate(roll_rate), .pitch_rate(pitch_rate),
        .yaw_rate(yaw_rate), .ctrl_done(ctrl_done)
    );

    motor_mixer mix0 (
        .sys_clk(sys_clk), .resetn(resetn), .ctrl_done(ctrl_done),
        .thr_cmd(thr_cmd), .roll_rate(roll_rate), .pitch_rate(pitch_rate),
        .yaw_rate(yaw_rate),
        .motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate)
    );

    esc_pwm esc0 (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm)
    );

endmodule

//--- dv/flight_core_assertions.sv
// Flight core strobe and pulse assertions
`timescale 1ns/1ps
`include "flight_cfg.svh"

module flight_core_assertions (
    input logic sys_clk,
    input logic resetn,
    input logic imu_valid,
    input logic ctrl_done,
    input logic us_pulse,
    input logic motor_1_pwm,
    input logic motor_2_pwm,
    input logic motor_3_pwm,
    input logic motor_4_pwm
);

    // Widest legal ESC pulse in cycles
    localparam int MAX_HIGH_CYC = (`ESC_MIN_US + `ESC_US_PER_STEP * `MOTOR_MAX) * `SYS_CLK_PER_US;

    logic [3:0]  pins;
    logic [15:0] high_cyc [4];

    assign pins = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

    // Length of the current high run per pin
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                high_cyc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                high_cyc[i] <= pins[i] ? high_cyc[i] + 16'd1 : 16'd0;
            end
        end
    end

    ctrl_done_follows: assert property (@(posedge sys_clk) disable iff (!resetn)
        imu_valid |=> ctrl_done) else $error("ctrl_done missing after imu_valid");

    ctrl_done_only_after_start: assert property (@(posedge sys_clk) disable iff (!resetn)
        !imu_valid |=> !ctrl_done) else $error("ctrl_done without imu_valid");

    us_pulse_single: assert property (@(posedge sys_clk) disable iff (!resetn)
        us_pulse |=> !us_pulse) else $error("us_pulse high for two cycles");

    // Never beyond the rate 250 width
    motor_1_width: assert property (@(posedge sys_clk) disable iff (!resetn)
        high_cyc[0] <= 16'(MAX_HIGH_CYC)) else $error("motor_1_pwm pulse too long");
    motor_2_width: assert property (@(posedge sys_clk) disable iff (!resetn)
        high_cyc[1] <= 16'(MAX_HIGH_CYC)) else $error("motor_2_pwm pulse too long");
    motor_3_width: assert property (@(posedge sys_clk) disable iff (!resetn)
        high_cyc[2] <= 16'(MAX_HIGH_CYC)) else $error("motor_3_pwm pulse too long");
    motor_4_width: assert property (@(posedge sys_clk) disable iff (!resetn)
        high_cyc[3] <= 16'(MAX_HIGH_CYC)) else $error("motor_4_pwm pulse too long");

endmodule

bind flight_core flight_core_assertions chk0 (
    .sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid),
    .ctrl_done(ctrl_done), .us_pulse(us_pulse),
    .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
    .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm)
);

//--- dv/flight_core_tb.sv
// Flight core testbench
`timescale 1ns/1ps
`include "flight_cfg.svh"

module flight_core_tb import flight_pkg::*; ();

    localparam int NUM_ROWS  = 12;
    localparam int NUM_FIXED = 8;

    logic   sys_clk;
    logic   resetn;
    logic   throttle_pwm;
    logic   roll_pwm;
    logic   pitch_pwm;
    logic   yaw_pwm;
    logic   imu_valid;
    angle_t roll_actual;
    angle_t pitch_actual;
    logic   motor_1_pwm;
    logic   motor_2_pwm;
    logic   motor_3_pwm;
    logic   motor_4_pwm;

    // Stick widths in us (throttle, roll, pitch, yaw), angles, expected ESC widths in us
    int tab_w     [NUM_ROWS][4];
    int tab_roll  [NUM_ROWS];
    int tab_pitch [NUM_ROWS];
    int tab_exp   [NUM_ROWS][4];

    int          meas_us [4];
    int          errors;
    int          checks;
    logic [31:0] lfsr;

    flight_core dut0 (
        .sys_clk(sys_clk), .resetn(resetn),
        .throttle_pwm(throttle_pwm), .roll_pwm(roll_pwm),
        .pitch_pwm(pitch_pwm), .yaw_pwm(yaw_pwm),
        .imu_valid(imu_valid), .roll_actual(roll_actual), .pitch_actual(pitch_actual),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm)
    );

    // 10 MHz, one us per ten cycles
    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    // Each row needs well under 10 ms, plus slack for reset and the first frame
    initial begin
        #(64'(NUM_ROWS) * 64'd10_000_000 + 64'd1_000_000);
        $display("Watchdog expired before all rows were checked");
        $display("TEST FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // Stick value from a pulse width
    function automatic int stick_value(input int w);
        int v;
        v = (w > `REC_MIN_US) ? (w - `REC_MIN_US) >> `REC_SHIFT : 0;
        return (v > 250) ? 250 : v;
    endfunction

    // Expected ESC widths for one row
    task automatic model_row(input int row);
        int thr;
        int r;
        int p;
        int y;
        int m [4];
        thr = stick_value(tab_w[row][0]);
        // Floor halving of each axis error
        r = (stick_value(tab_w[row][1]) - `REC_CENTER - tab_roll[row]) >>> `AXIS_SHIFT;
        p = (stick_value(tab_w[row][2]) - `REC_CENTER - tab_pitch[row]) >>> `AXIS_SHIFT;
        y = (stick_value(tab_w[row][3]) - `REC_CENTER) >>> `AXIS_SHIFT;
        m[0] = thr + p + r - y;
        m[1] = thr + p - r + y;
        m[2] = thr - p - r - y;
        m[3] = thr - p + r + y;
        for (int i = 0; i < 4; i++) begin
            if (thr < `THROTTLE_IDLE || m[i] < 0) begin
                m[i] = 0;
            end else if (m[i] > `MOTOR_MAX) begin
                m[i] = `MOTOR_MAX;
            end
            tab_exp[row][i] = `ESC_MIN_US + `ESC_US_PER_STEP * m[i];
        end
    endtask

    task automatic set_row(input int row, input int tw, input int rw, input int pw,
                           input int yw, input int ra, input int pa);
        tab_w[row][0] = tw;
        tab_w[row][1] = rw;
        tab_w[row][2] = pw;
        tab_w[row][3] = yw;
        tab_roll[row]  = ra;
        tab_pitch[row] = pa;
    endtask

    task automatic fill_table();
        int bits;
        set_row(0, 1500, 1500, 1500, 1500, 0, 0);
        // Throttle stick 5, below idle
        set_row(1, 1020, 2000, 1000, 1800, 20, -30);
        set_row(2, 1500, 2000, 1500, 1500, 0, 0);
        set_row(3, 1500, 1500, 1000, 1500, 0, -40);
        set_row(4, 1500, 1500, 1500, 1100, 0, 0);
        // Drives both ends of the motor range
        set_row(5, 2000, 2000, 2000, 2000, -128, -128);
        set_row(6, 2150, 900, 2200, 950, 0, 0);
        // Odd errors exercise the floor rounding
        set_row(7, 1303, 1501, 1498, 1502, 17, 33);
        for (int row = NUM_FIXED; row < NUM_ROWS; row++) begin
            for (int ch = 0; ch < 4; ch++) begin
                draw_bits(11, bits);
                tab_w[row][ch] = 900 + bits % 1300;
            end
            draw_bits(7, bits);
            tab_roll[row] = bits - 64;
            draw_bits(7, bits);
            tab_pitch[row] = bits - 64;
        end
        for (int row = 0; row < NUM_ROWS; row++) begin
            model_row(row);
        end
    endtask

    // All four RC pulses rise together, each falls at its own width
    task automatic send_sticks(input int row);
        int max_cyc;
        max_cyc = 0;
        for (int ch = 0; ch < 4; ch++) begin
            if (tab_w[row][ch] * `SYS_CLK_PER_US > max_cyc) begin
                max_cyc = tab_w[row][ch] * `SYS_CLK_PER_US;
            end
        end
        for (int c = 0; c <= max_cyc; c++) begin
            @(posedge sys_clk);
            throttle_pwm <= (c < tab_w[row][0] * `SYS_CLK_PER_US);
            roll_pwm     <= (c < tab_w[row][1] * `SYS_CLK_PER_US);
            pitch_pwm    <= (c < tab_w[row][2] * `SYS_CLK_PER_US);
            yaw_pwm      <= (c < tab_w[row][3] * `SYS_CLK_PER_US);
        end
        // Synchronizer plus value register
        repeat (5) @(posedge sys_clk);
        roll_actual  <= angle_t'(tab_roll[row]);
        pitch_actual <= angle_t'(tab_pitch[row]);
        imu_valid    <= 1'b1;
        @(posedge sys_clk);
        imu_valid <= 1'b0;
    endtask

    // Returns at the first falling-edge sample with the frame's pulses high
    task automatic wait_frame_start();
        logic prev;
        @(negedge sys_clk);
        do begin
            prev = motor_1_pwm;
            @(negedge sys_clk);
        end while (prev || !motor_1_pwm);
    endtask

    task automatic measure_frame();
        int         cyc [4];
        logic [3:0] pins;
        for (int i = 0; i < 4; i++) begin
            cyc[i] = 0;
        end
        pins = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
        while (pins != 4'b0000) begin
            for (int i = 0; i < 4; i++) begin
                cyc[i] += int'(pins[i]);
            end
            @(negedge sys_clk);
            pins = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
        end
        for (int i = 0; i < 4; i++) begin
            meas_us[i] = cyc[i] / `SYS_CLK_PER_US;
        end
    endtask

    task automatic check_width(input string label, input int motor, input int exp_us);
        checks++;
        assert (meas_us[motor] == exp_us) else begin
            $display("FAILED %s motor_%0d_pwm width_us exp=%h got=%h",
                     label, motor + 1, exp_us, meas_us[motor]);
            errors++;
        end
    endtask

    initial begin
        resetn       <= 1'b0;
        throttle_pwm <= 1'b0;
        roll_pwm     <= 1'b0;
        pitch_pwm    <= 1'b0;
        yaw_pwm      <= 1'b0;
        imu_valid    <= 1'b0;
        roll_actual  <= '0;
        pitch_actual <= '0;
        errors = 0;
        checks = 0;
        lfsr   = 32'h490594df;
        fill_table();
        // Eight reset cycles, then a few idle ones before the first tick
        for (int c = 0; c < 12; c++) begin
            @(posedge sys_clk);
            if (c == 7) begin
                resetn <= 1'b1;
            end
            @(negedge sys_clk);
            checks++;
            assert ({motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm} == 4'b0000) else begin
                $display("FAILED motor_pwm at cycle %0d exp=%h got=%h", c, 4'b0000,
                         {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm});
                errors++;
            end
        end
        wait_frame_start();
        measure_frame();
        for (int i = 0; i < 4; i++) begin
            check_width("first frame", i, `ESC_MIN_US);
        end
        for (int row = 0; row < NUM_ROWS; row++) begin
            send_sticks(row);
            // Skip the frame that may still hold the old rates
            wait_frame_start();
            wait_frame_start();
            measure_frame();
            for (int i = 0; i < 4; i++) begin
                check_width($sformatf("row %0d", row), i, tab_exp[row][i]);
            end
        end
        $display("Done, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+rtl
rtl/flight_pkg.sv
rtl/us_tick.sv
rtl/rc_receiver.sv
rtl/angle_controller.sv
rtl/motor_mixer.sv
rtl/esc_pwm.sv
rtl/flight_core.sv
dv/flight_core_assertions.sv
dv/flight_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the flight core simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module flight_core_tb -f flist.f -o flight_sim

# The simulator output decides the result
result=$(./obj_dir/flight_sim 2>&1) || true
echo "$result"

if echo "$result" | grep -qx "TEST OK"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
